// File: run_sim.sh
#!/bin/sh
# Build the shared TLB testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module stlb_tb -f sources.f -o stlb_sim \
	&& ./obj_dir/stlb_sim > sim.log 2>&1 \
	|| { echo "Build or simulation did not complete"; exit 1; }
cat sim.log
if grep -q "TEST FAILED" sim.log; then
	echo "Simulation reported failure"
	exit 1
fi
echo "Simulation reported no failure"
exit 0

// File: sim/stlb_tb.sv
// ====================================================================
// Testbench for the shared TLB: clock, reset, stimulus table,
// apply loop, result checker and closing summary
// ====================================================================
`timescale 1ns/1ps
`default_nettype none

`include "stlb_consts.svh"

module stlb_tb;

	typedef enum logic [1:0] {
		ROW_REG,
		ROW_WAIT,
		ROW_LOOKUP
	} row_kind_e;

	// One line of the stimulus table
	typedef struct packed {
		row_kind_e kind;
		stlb_pkg::reg_sel_e sel;
		stlb_pkg::addr_t dat;
		stlb_pkg::addr_t vadr;
		stlb_pkg::asid_t asid;
		stlb_pkg::om_e om;
		logic miss;
		stlb_pkg::addr_t padr;
		stlb_pkg::rwx_t rwx;
	} row_t;

	// Result still owed by the DUT, with the cycle it is due in
	typedef struct packed {
		logic miss;
		stlb_pkg::addr_t padr;
		stlb_pkg::rwx_t rwx;
		logic [31:0] due;
	} expect_t;

	logic clk_g;
	logic rst_i;
	logic reg_we_i;
	stlb_pkg::reg_sel_e reg_sel_i;
	stlb_pkg::addr_t reg_dat_i;
	logic rdy_o;
	logic xlat_v_i;
	stlb_pkg::addr_t vadr_i;
	stlb_pkg::asid_t asid_i;
	stlb_pkg::om_e om_i;
	logic xlat_v_o;
	stlb_pkg::addr_t padr_o;
	stlb_pkg::rwx_t rwx_o;
	logic miss_o;

	row_t rows[$];
	expect_t pending[$];
	logic [31:0] cyc = '0;
	integer seed = 32'h349cb848;
	int errors = 0;
	int timeouts = 0;

	stlb_top stlb_top_i (
		.clk_g(clk_g),
		.rst_i(rst_i),
		.reg_we_i(reg_we_i),
		.reg_sel_i(reg_sel_i),
		.reg_dat_i(reg_dat_i),
		.rdy_o(rdy_o),
		.xlat_v_i(xlat_v_i),
		.vadr_i(vadr_i),
		.asid_i(asid_i),
		.om_i(om_i),
		.xlat_v_o(xlat_v_o),
		.padr_o(padr_o),
		.rwx_o(rwx_o),
		.miss_o(miss_o)
	);

	initial begin
		clk_g = 1'b0;
		forever #20 clk_g = ~clk_g;
	end

	always @(posedge clk_g)
		cyc <= cyc + 32'd1;

	// ================================================================
	// Compare tasks
	// ================================================================

	task automatic check_padr(input stlb_pkg::addr_t got, input stlb_pkg::addr_t exp);
		if (got !== exp) begin
			$display("ERROR padr_o got %h expected %h", got, exp);
			errors++;
		end
	endtask

	task automatic check_rwx(input stlb_pkg::rwx_t got, input stlb_pkg::rwx_t exp);
		if (got !== exp) begin
			$display("ERROR rwx_o got %h expected %h", got, exp);
			errors++;
		end
	endtask

	task automatic check_miss(input logic got, input logic exp);
		if (got !== exp) begin
			$display("ERROR miss_o got %h expected %h", got, exp);
			errors++;
		end
	endtask

	// ================================================================
	// Register words and expected rights
	// ================================================================

	function automatic stlb_pkg::addr_t pte_word(input stlb_pkg::ppn_t ppn, input logic gbl,
		input stlb_pkg::rwx_t u, input stlb_pkg::rwx_t s, input stlb_pkg::rwx_t h);
		stlb_pkg::addr_t w;
		w = '0;
		w[`STLB_PTE_PPN_LO +: `STLB_PPN_W] = ppn;
		w[`STLB_PTE_V] = 1'b1;
		w[`STLB_PTE_G] = gbl;
		w[`STLB_PTE_URWX_LO +: 3] = u;
		w[`STLB_PTE_SRWX_LO +: 3] = s;
		w[`STLB_PTE_HRWX_LO +: 3] = h;
		return w;
	endfunction

	function automatic stlb_pkg::addr_t vpn_word(input logic [15:0] vpage,
		input stlb_pkg::asid_t asid);
		stlb_pkg::addr_t w;
		w = '0;
		w[`STLB_VPN_LO +: 16] = vpage;
		w[`STLB_VPN_ASID_LO +: `STLB_ASID_W] = asid;
		return w;
	endfunction

	function automatic stlb_pkg::addr_t ctrl_word(input stlb_pkg::stlb_cmd_e cmd,
		input logic [1:0] way);
		stlb_pkg::addr_t w;
		w = '0;
		w[`STLB_CTRL_CMD_LO +: 2] = cmd;
		w[`STLB_CTRL_WAY_LO +: 2] = way;
		return w;
	endfunction

	// Machine mode gets every right, the others their own field
	function automatic stlb_pkg::rwx_t rights_for(input stlb_pkg::om_e om,
		input stlb_pkg::rwx_t u, input stlb_pkg::rwx_t s, input stlb_pkg::rwx_t h);
		case (om)
		stlb_pkg::OM_APP: return u;
		stlb_pkg::OM_SUP: return s;
		stlb_pkg::OM_HYP: return h;
		default: return 3'b111;
		endcase
	endfunction

	// ================================================================
	// Table building
	// ================================================================

	task automatic reg_write_row(input stlb_pkg::reg_sel_e sel, input stlb_pkg::addr_t dat);
		row_t r;
		r = '0;
		r.kind = ROW_REG;
		r.sel = sel;
		r.dat = dat;
		rows.push_back(r);
	endtask

	task automatic ready_row();
		row_t r;
		r = '0;
		r.kind = ROW_WAIT;
		rows.push_back(r);
	endtask

	// Fresh random page offset on every lookup
	task automatic lookup_row(input logic [15:0] vpage, input stlb_pkg::asid_t asid,
		input stlb_pkg::om_e om, input logic hit, input stlb_pkg::ppn_t ppn,
		input stlb_pkg::rwx_t u, input stlb_pkg::rwx_t s, input stlb_pkg::rwx_t h);
		row_t r;
		logic [31:0] rnd;
		rnd = $random(seed);
		r = '0;
		r.kind = ROW_LOOKUP;
		r.vadr = {vpage, rnd[15:0]};
		r.asid = asid;
		r.om = om;
		r.miss = ~hit;
		if (hit) begin
			r.padr = {ppn, rnd[15:0]};
			r.rwx = rights_for(om, u, s, h);
		end
		rows.push_back(r);
	endtask

	task automatic load_entry(input logic [1:0] way, input logic [15:0] vpage,
		input stlb_pkg::asid_t asid, input stlb_pkg::ppn_t ppn, input logic gbl,
		input stlb_pkg::rwx_t u, input stlb_pkg::rwx_t s, input stlb_pkg::rwx_t h);
		reg_write_row(stlb_pkg::REG_PTE, pte_word(ppn, gbl, u, s, h));
		reg_write_row(stlb_pkg::REG_VPN, vpn_word(vpage, asid));
		reg_write_row(stlb_pkg::REG_CTRL, ctrl_word(stlb_pkg::CMD_WRITE, way));
		ready_row();
	endtask

	task automatic sweep_all();
		reg_write_row(stlb_pkg::REG_CTRL, ctrl_word(stlb_pkg::CMD_INVALL, 2'd0));
		ready_row();
	endtask

	task automatic build_table();
		// Empty TLB after the sweep
		sweep_all();
		lookup_row(16'h0000, 8'h00, stlb_pkg::OM_APP, 1'b0, '0, '0, '0, '0);
		lookup_row(16'h1234, 8'h5A, stlb_pkg::OM_SUP, 1'b0, '0, '0, '0, '0);
		lookup_row(16'hFFFF, 8'hFF, stlb_pkg::OM_MACH, 1'b0, '0, '0, '0, '0);
		lookup_row(16'hA5F0, 8'h5A, stlb_pkg::OM_HYP, 1'b0, '0, '0, '0, '0);
		// Private entry in way 2, all four modes
		load_entry(2'd2, 16'h1234, 8'h5A, 16'hBEEF, 1'b0, 3'b100, 3'b110, 3'b011);
		lookup_row(16'h1234, 8'h5A, stlb_pkg::OM_APP, 1'b1, 16'hBEEF, 3'b100, 3'b110, 3'b011);
		lookup_row(16'h1234, 8'h5A, stlb_pkg::OM_SUP, 1'b1, 16'hBEEF, 3'b100, 3'b110, 3'b011);
		lookup_row(16'h1234, 8'h5A, stlb_pkg::OM_HYP, 1'b1, 16'hBEEF, 3'b100, 3'b110, 3'b011);
		lookup_row(16'h1234, 8'h5A, stlb_pkg::OM_MACH, 1'b1, 16'hBEEF, 3'b100, 3'b110, 3'b011);
		// Foreign ASID, then the same page made global
		lookup_row(16'h1234, 8'h33, stlb_pkg::OM_APP, 1'b0, '0, '0, '0, '0);
		load_entry(2'd2, 16'h1234, 8'h5A, 16'hBEEF, 1'b1, 3'b100, 3'b110, 3'b011);
		lookup_row(16'h1234, 8'h33, stlb_pkg::OM_SUP, 1'b1, 16'hBEEF, 3'b100, 3'b110, 3'b011);
		// Way 1 shadows way 2 at the same index and tag
		load_entry(2'd1, 16'h1234, 8'h5A, 16'h0C0D, 1'b0, 3'b111, 3'b101, 3'b001);
		load_entry(2'd0, 16'hA5F0, 8'h5A, 16'h4321, 1'b0, 3'b010, 3'b011, 3'b100);
		lookup_row(16'h1234, 8'h5A, stlb_pkg::OM_APP, 1'b1, 16'h0C0D, 3'b111, 3'b101, 3'b001);
		lookup_row(16'h7777, 8'h5A, stlb_pkg::OM_SUP, 1'b0, '0, '0, '0, '0);
		lookup_row(16'hA5F0, 8'h5A, stlb_pkg::OM_HYP, 1'b1, 16'h4321, 3'b010, 3'b011, 3'b100);
		lookup_row(16'h1234, 8'h33, stlb_pkg::OM_HYP, 1'b1, 16'hBEEF, 3'b100, 3'b110, 3'b011);
		lookup_row(16'hA5F0, 8'h5A, stlb_pkg::OM_MACH, 1'b1, 16'h4321, 3'b010, 3'b011, 3'b100);
		lookup_row(16'h1235, 8'h5A, stlb_pkg::OM_APP, 1'b0, '0, '0, '0, '0);
		// Sweep again, every earlier hit is gone
		sweep_all();
		lookup_row(16'h1234, 8'h5A, stlb_pkg::OM_APP, 1'b0, '0, '0, '0, '0);
		lookup_row(16'h1234, 8'h33, stlb_pkg::OM_SUP, 1'b0, '0, '0, '0, '0);
		lookup_row(16'hA5F0, 8'h5A, stlb_pkg::OM_MACH, 1'b0, '0, '0, '0, '0);
	endtask

	// ================================================================
	// Apply loop and result checker
	// ================================================================

	task automatic apply_row(input row_t r);
		expect_t e;
		int n;
		@(negedge clk_g);
		reg_we_i = 1'b0;
		xlat_v_i = 1'b0;
		case (r.kind)
		ROW_REG: begin
			reg_we_i = 1'b1;
			reg_sel_i = r.sel;
			reg_dat_i = r.dat;
		end
		ROW_WAIT: begin
			n = 0;
			while (!rdy_o && n < 100) begin
				@(negedge clk_g);
				n++;
			end
			if (!rdy_o) begin
				$display("Timeout: rdy_o stayed low for 100 cycles");
				timeouts++;
			end
		end
		default: begin
			xlat_v_i = 1'b1;
			vadr_i = r.vadr;
			asid_i = r.asid;
			om_i = r.om;
			e.miss = r.miss;
			e.padr = r.padr;
			e.rwx = r.rwx;
			// Sampled at the next edge, result registered one edge later
			e.due = cyc + 32'd2;
			pending.push_back(e);
		end
		endcase
	endtask

	initial begin
		expect_t e;
		forever begin
			@(negedge clk_g);
			if (xlat_v_o === 1'b1) begin
				if (pending.size() == 0) begin
					$display("Lookup result appeared with no request outstanding");
					errors++;
				end else begin
					e = pending.pop_front();
					if (e.due != cyc) begin
						$display("Lookup result came in cycle %0d, due in %0d", cyc, e.due);
						errors++;
					end
					check_miss(miss_o, e.miss);
					check_padr(padr_o, e.padr);
					check_rwx(rwx_o, e.rwx);
				end
			end else if (pending.size() != 0 && pending[0].due <= cyc) begin
				$display("No lookup result in cycle %0d", cyc);
				errors++;
				e = pending.pop_front();
			end
		end
	end

	initial begin
		int n;
		rst_i = 1'b1;
		reg_we_i = 1'b0;
		reg_sel_i = stlb_pkg::REG_PTE;
		reg_dat_i = '0;
		xlat_v_i = 1'b0;
		vadr_i = '0;
		asid_i = '0;
		om_i = stlb_pkg::OM_APP;
		build_table();
		repeat (8) @(posedge clk_g);
		@(negedge clk_g);
		rst_i = 1'b0;
		foreach (rows[i])
			apply_row(rows[i]);
		@(negedge clk_g);
		reg_we_i = 1'b0;
		xlat_v_i = 1'b0;
		n = 0;
		while (pending.size() != 0 && n < 100) begin
			@(negedge clk_g);
			n++;
		end
		if (pending.size() != 0) begin
			$display("Timeout: lookup results still outstanding after 100 cycles");
			timeouts++;
		end
		$display("Errors: %0d, timeouts: %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: source/stlb_consts.svh
// ====================================================================
// Widths, way and entry counts of the shared TLB
// Field positions of the PTE, VPN and control registers
// ====================================================================
`ifndef STLB_CONSTS_SVH
`define STLB_CONSTS_SVH

// Address space and page geometry
`define STLB_ADDR_W       32
`define STLB_LOG_PAGE     16
`define STLB_ASID_W       8
`define STLB_PPN_W        16

// Ways and entries per way
`define STLB_ASSOC        4
`define STLB_WAY_W        2
`define STLB_LOG_ENTRIES  4
`define STLB_ENTRIES      16

// Tag is what is left above the page offset and the index
`define STLB_TAG_W        (`STLB_ADDR_W - `STLB_LOG_PAGE - `STLB_LOG_ENTRIES)

// PTE register fields
`define STLB_PTE_PPN_LO   0
`define STLB_PTE_V        16
`define STLB_PTE_G        17
`define STLB_PTE_URWX_LO  18
`define STLB_PTE_SRWX_LO  21
`define STLB_PTE_HRWX_LO  24

// VPN register fields
`define STLB_VPN_LO       0
`define STLB_VPN_ASID_LO  16

// Control register fields
`define STLB_CTRL_CMD_LO  0
`define STLB_CTRL_WAY_LO  4

`endif

// File: source/stlb_entry_ram.sv
// ====================================================================
// Entry memory of one TLB way, one write and one read port
// ====================================================================
`timescale 1ns/1ps
`default_nettype none

`include "stlb_consts.svh"

module stlb_entry_ram (
	input wire clk_g,

	// Maintenance write side
	input wire wr_en_i,
	input wire [`STLB_LOG_ENTRIES-1:0] wr_idx_i,
	input wire stlb_pkg::stlb_entry_t wr_dat_i,

	// Lookup read side
	input wire rd_en_i,
	input wire [`STLB_LOG_ENTRIES-1:0] rd_idx_i,
	output stlb_pkg::stlb_entry_t rd_dat_o
);

	// Laid out like a simple dual-port block RAM
	stlb_pkg::stlb_entry_t mem [0:`STLB_ENTRIES-1];

	always_ff @(posedge clk_g) begin
		if (wr_en_i)
			mem[wr_idx_i] <= wr_dat_i;
	end

	// Registered read, data valid one cycle after the request
	always_ff @(posedge clk_g) begin
		if (rd_en_i)
			rd_dat_o <= mem[rd_idx_i];
	end

endmodule

`default_nettype wire

// File: source/stlb_lookup.sv
// ====================================================================
// Tag compare over all ways, hit select, rights and physical address
// ====================================================================
`timescale 1ns/1ps
`default_nettype none

`include "stlb_consts.svh"

module stlb_lookup (
	input wire clk_g,
	input wire rst_i,

	input wire xlat_v_i,
	input wire stlb_pkg::addr_t vadr_i,
	input wire stlb_pkg::asid_t asid_i,
	input wire stlb_pkg::om_e om_i,

	// Entries read from each way, one cycle after the request
	input wire stlb_pkg::stlb_entry_t [`STLB_ASSOC-1:0] way_dat_i,

	output logic xlat_v_o,
	output stlb_pkg::addr_t padr_o,
	output stlb_pkg::rwx_t rwx_o,
	output logic miss_o
);

	logic v_d;
	stlb_pkg::addr_t vadr_d;
	stlb_pkg::asid_t asid_d;
	stlb_pkg::om_e om_d;

	logic [`STLB_ASSOC-1:0] way_hit;
	logic hit;
	stlb_pkg::stlb_entry_t sel;
	stlb_pkg::rwx_t rwx;
	stlb_pkg::addr_t padr;

	// ================================================================
	// Request delay, lines up with the RAM read data
	// ================================================================

	always_ff @(posedge clk_g, posedge rst_i) begin
		if (rst_i)
			v_d <= 1'b0;
		else
			v_d <= xlat_v_i;
	end

	always_ff @(posedge clk_g) begin
		vadr_d <= vadr_i;
		asid_d <= asid_i;
		om_d <= om_i;
	end

	// ================================================================
	// Compare and select
	// ================================================================

	// Valid, same tag, and same ASID unless the page is global
	always_comb begin
		for (int w = 0; w < `STLB_ASSOC; w++) begin
			way_hit[w] = way_dat_i[w].valid &&
				way_dat_i[w].tag == vadr_d[`STLB_ADDR_W-1 -: `STLB_TAG_W] &&
				(way_dat_i[w].asid == asid_d || way_dat_i[w].gbl);
		end
	end

	// Scan from the top so the lowest hitting way is kept
	always_comb begin
		hit = 1'b0;
		sel = '0;
		for (int w = `STLB_ASSOC - 1; w >= 0; w--) begin
			if (way_hit[w]) begin
				hit = 1'b1;
				sel = way_dat_i[w];
			end
		end
	end

	always_comb begin
		case (om_d)
		stlb_pkg::OM_APP:
			rwx = sel.urwx;
		stlb_pkg::OM_SUP:
			rwx = sel.srwx;
		stlb_pkg::OM_HYP:
			rwx = sel.hrwx;
		default:
			rwx = 3'b111;
		endcase
	end

	// Page frame joined to the untranslated offset
	assign padr = {sel.ppn, vadr_d[`STLB_LOG_PAGE-1:0]};

	// ================================================================
	// Result register
	// ================================================================

	always_ff @(posedge clk_g, posedge rst_i) begin
		if (rst_i) begin
			xlat_v_o <= 1'b0;
			miss_o <= 1'b0;
		end else begin
			xlat_v_o <= v_d;
			miss_o <= v_d & ~hit;
		end
	end

	// Zero on a miss or when there is no request
	always_ff @(posedge clk_g) begin
		if (v_d && hit) begin
			padr_o <= padr;
			rwx_o <= rwx;
		end else begin
			padr_o <= '0;
			rwx_o <= '0;
		end
	end

endmodule

`default_nettype wire

// File: source/stlb_maint.sv
// ====================================================================
// Maintenance registers, command decode and the write/invalidate FSM
// ====================================================================
`timescale 1ns/1ps
`default_nettype none

`include "stlb_consts.svh"

module stlb_maint (
	input wire clk_g,
	input wire rst_i,

	input wire reg_we_i,
	input wire stlb_pkg::reg_sel_e reg_sel_i,
	input wire stlb_pkg::addr_t reg_dat_i,
	output logic rdy_o,

	output logic [`STLB_ASSOC-1:0] wr_en_o,
	output logic [`STLB_LOG_ENTRIES-1:0] wr_idx_o,
	output stlb_pkg::stlb_entry_t wr_dat_o
);

	stlb_pkg::addr_t pte_reg;
	stlb_pkg::addr_t vpn_reg;
	stlb_pkg::addr_t ctrl_reg;
	stlb_pkg::maint_state_e state;
	stlb_pkg::stlb_cmd_e cmd;
	logic [`STLB_LOG_ENTRIES-1:0] inv_idx;
	logic [`STLB_WAY_W-1:0] way;

	always_comb begin
		cmd = stlb_pkg::stlb_cmd_e'(reg_dat_i[`STLB_CTRL_CMD_LO +: 2]);
		way = ctrl_reg[`STLB_CTRL_WAY_LO +: `STLB_WAY_W];
	end

	// ================================================================
	// Register writes and FSM
	// ================================================================

	always_ff @(posedge clk_g, posedge rst_i) begin
		if (rst_i) begin
			pte_reg <= '0;
			vpn_reg <= '0;
			ctrl_reg <= '0;
			state <= stlb_pkg::ST_RUN;
			inv_idx <= '0;
		end else begin
			if (reg_we_i) begin
				case (reg_sel_i)
				stlb_pkg::REG_PTE:
					pte_reg <= reg_dat_i;
				stlb_pkg::REG_VPN:
					vpn_reg <= reg_dat_i;
				stlb_pkg::REG_CTRL:
					// Commands only start from the idle state
					if (state == stlb_pkg::ST_RUN) begin
						ctrl_reg <= reg_dat_i;
						if (cmd == stlb_pkg::CMD_WRITE)
							state <= stlb_pkg::ST_WRITE;
						else if (cmd == stlb_pkg::CMD_INVALL) begin
							state <= stlb_pkg::ST_INVALL;
							inv_idx <= '0;
						end
					end
				default: ;
				endcase
			end

			case (state)
			stlb_pkg::ST_WRITE:
				state <= stlb_pkg::ST_RUN;
			stlb_pkg::ST_INVALL: begin
				inv_idx <= inv_idx + 1'b1;
				if (inv_idx == `STLB_LOG_ENTRIES'(`STLB_ENTRIES - 1))
					state <= stlb_pkg::ST_RUN;
			end
			stlb_pkg::ST_RUN: ;
			default:
				state <= stlb_pkg::ST_RUN;
			endcase
		end
	end

	assign rdy_o = (state == stlb_pkg::ST_RUN);

	// ================================================================
	// Write port drive
	// ================================================================

	// Entry assembled from the held PTE and VPN, all zero while sweeping
	always_comb begin
		wr_dat_o = '0;
		if (state == stlb_pkg::ST_WRITE) begin
			wr_dat_o.valid = pte_reg[`STLB_PTE_V];
			wr_dat_o.gbl = pte_reg[`STLB_PTE_G];
			wr_dat_o.asid = vpn_reg[`STLB_VPN_ASID_LO +: `STLB_ASID_W];
			wr_dat_o.tag = vpn_reg[`STLB_VPN_LO + `STLB_LOG_ENTRIES +: `STLB_TAG_W];
			wr_dat_o.ppn = pte_reg[`STLB_PTE_PPN_LO +: `STLB_PPN_W];
			wr_dat_o.urwx = pte_reg[`STLB_PTE_URWX_LO +: 3];
			wr_dat_o.srwx = pte_reg[`STLB_PTE_SRWX_LO +: 3];
			wr_dat_o.hrwx = pte_reg[`STLB_PTE_HRWX_LO +: 3];
		end
	end

	always_comb begin
		wr_en_o = '0;
		wr_idx_o = inv_idx;
		case (state)
		stlb_pkg::ST_WRITE: begin
			wr_en_o[way] = 1'b1;
			wr_idx_o = vpn_reg[`STLB_VPN_LO +: `STLB_LOG_ENTRIES];
		end
		stlb_pkg::ST_INVALL:
			wr_en_o = '1;
		default: ;
		endcase
	end

endmodule

`default_nettype wire

// File: source/stlb_pkg.sv
// ====================================================================
// Shared TLB types: address, entry, modes, commands, states
// ====================================================================
`default_nettype none

`include "stlb_consts.svh"

package stlb_pkg;

	typedef logic [`STLB_ADDR_W-1:0] addr_t;
	typedef logic [`STLB_PPN_W-1:0] ppn_t;
	typedef logic [`STLB_ASID_W-1:0] asid_t;

	// Read at bit 2, write at bit 1, execute at bit 0
	typedef logic [2:0] rwx_t;

	typedef enum logic [1:0] {
		OM_APP  = 2'd0,
		OM_SUP  = 2'd1,
		OM_HYP  = 2'd2,
		OM_MACH = 2'd3
	} om_e;

	typedef enum logic [1:0] {
		CMD_NONE   = 2'd0,
		CMD_WRITE  = 2'd1,
		CMD_INVALL = 2'd2
	} stlb_cmd_e;

	typedef enum logic [1:0] {
		REG_PTE  = 2'd0,
		REG_VPN  = 2'd1,
		REG_CTRL = 2'd2
	} reg_sel_e;

	typedef enum logic [1:0] {
		ST_RUN    = 2'd0,
		ST_WRITE  = 2'd1,
		ST_INVALL = 2'd2
	} maint_state_e;

	// One TLB entry as held in a way
	typedef struct packed {
		logic valid;
		logic gbl;
		asid_t asid;
		logic [`STLB_TAG_W-1:0] tag;
		ppn_t ppn;
		rwx_t urwx;
		rwx_t srwx;
		rwx_t hrwx;
	} stlb_entry_t;

endpackage

`default_nettype wire

// File: source/stlb_top.sv
// ====================================================================
// Shared TLB top: maintenance, four entry memories and lookup
// ====================================================================
`timescale 1ns/1ps
`default_nettype none

`include "stlb_consts.svh"

module stlb_top (
	input wire clk_g,
	input wire rst_i,

	// Maintenance register port
	input wire reg_we_i,
	input wire stlb_pkg::reg_sel_e reg_sel_i,
	input wire stlb_pkg::addr_t reg_dat_i,
	output logic rdy_o,

	// Lookup request
	input wire xlat_v_i,
	input wire stlb_pkg::addr_t vadr_i,
	input wire stlb_pkg::asid_t asid_i,
	input wire stlb_pkg::om_e om_i,

	// Lookup result
	output logic xlat_v_o,
	output stlb_pkg::addr_t padr_o,
	output stlb_pkg::rwx_t rwx_o,
	output logic miss_o
);

	logic [`STLB_ASSOC-1:0] wr_en;
	logic [`STLB_LOG_ENTRIES-1:0] wr_idx;
	stlb_pkg::stlb_entry_t wr_dat;
	stlb_pkg::stlb_entry_t [`STLB_ASSOC-1:0] rd_dat;

	// Lookups are dropped while maintenance owns the ways
	wire xlat_go = xlat_v_i & rdy_o;

	stlb_maint stlb_maint_i (
		.clk_g(clk_g),
		.rst_i(rst_i),
		.reg_we_i(reg_we_i),
		.reg_sel_i(reg_sel_i),
		.reg_dat_i(reg_dat_i),
		.rdy_o(rdy_o),
		.wr_en_o(wr_en),
		.wr_idx_o(wr_idx),
		.wr_dat_o(wr_dat)
	);

	for (genvar g = 0; g < `STLB_ASSOC; g++) begin : g_way
		stlb_entry_ram stlb_entry_ram_i (
			.clk_g(clk_g),
			.wr_en_i(wr_en[g]),
			.wr_idx_i(wr_idx),
			.wr_dat_i(wr_dat),
			.rd_en_i(xlat_go),
			.rd_idx_i(vadr_i[`STLB_LOG_PAGE +: `STLB_LOG_ENTRIES]),
			.rd_dat_o(rd_dat[g])
		);
	end

	stlb_lookup stlb_lookup_i (
		.clk_g(clk_g),
		.rst_i(rst_i),
		.xlat_v_i(xlat_go),
		.vadr_i(vadr_i),
		.asid_i(asid_i),
		.om_i(om_i),
		.way_dat_i(rd_dat),
		.xlat_v_o(xlat_v_o),
		.padr_o(padr_o),
		.rwx_o(rwx_o),
		.miss_o(miss_o)
	);

endmodule

`default_nettype wire

// File: sources.f
+incdir+source
source/stlb_pkg.sv
source/stlb_entry_ram.sv
source/stlb_maint.sv
source/stlb_lookup.sv
source/stlb_top.sv
sim/stlb_tb.sv
